// File: verilog/me_stream_pkg.sv
/*
 * shared opcodes, widths and stream masks for the memory endpoint
 * each module imports this package inside its body and uses scoped names in its ports
 */
package me_stream_pkg;

  // message opcode, the uncached types behave like their cached twins
  typedef enum logic [1:0]
  {
    e_rd_msg    = 2'b00
    , e_wr_msg    = 2'b01
    , e_uc_rd_msg = 2'b10
    , e_uc_wr_msg = 2'b11
  } me_msg_type_e;

  localparam int stream_data_width   = 64;
  localparam int block_width         = 512;
  localparam int stream_words        = block_width / stream_data_width;
  localparam int data_len_width      = 3;
  localparam int stream_offset_width = 3;
  localparam int block_offset_width  = 6;
  localparam int paddr_width         = 32;
  localparam int size_width          = 3;
  localparam int mem_words           = 64;
  localparam int mem_addr_width      = 6;

  // types that may carry several beats on the fsm side, reads expand 1:N
  localparam logic [3:0] fsm_stream_mask = (4'b1 << e_rd_msg) | (4'b1 << e_uc_rd_msg)
                                         | (4'b1 << e_wr_msg) | (4'b1 << e_uc_wr_msg);
  // types that may carry several beats on the stream side, writes sit in both masks
  localparam logic [3:0] msg_stream_mask = (4'b1 << e_wr_msg) | (4'b1 << e_uc_wr_msg);

  // number of word beats minus one for a size field holding log2 of the byte count
  // sizes of one word or less give a single beat
  function automatic logic [data_len_width-1:0] stream_len
    (input logic [size_width-1:0] size);
    logic [data_len_width-1:0] len;
    len = '0;
    if (size > stream_offset_width)
    begin
      len = data_len_width'((1 << (size - stream_offset_width)) - 1);
    end
    return len;
  endfunction

endpackage

// File: verilog/me_two_fifo.sv
/*
 * two-entry buffer, valid/ready-and on the input and valid/yumi on the output
 * every entry adds one cycle, there is no bypass from input to output
 */
`timescale 1ns/1ps

module me_two_fifo
  #(parameter int width_p = 8)
  (input                      clk_i
   , input                    reset_i

   , input        [width_p-1:0] data_i
   , input                    v_i
   , output logic             ready_o

   , output logic [width_p-1:0] data_o
   , output logic             v_o
   , input                    yumi_i
   );

  // storage slots carry payload only and keep whatever they held over reset
  logic [width_p-1:0] slot_r [2];
  logic rptr_r, wptr_r, full_r;
  logic enq, deq;

  // equal pointers mean empty unless the full bit is set
  assign ready_o = ~full_r;
  assign v_o     = full_r | (rptr_r != wptr_r);
  assign data_o  = slot_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i;

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      slot_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rptr_r <= 1'b0;
      wptr_r <= 1'b0;
      full_r <= 1'b0;
    end
    else
    begin
      rptr_r <= rptr_r ^ deq;
      wptr_r <= wptr_r ^ enq;
      // fills when a lone write closes the gap, drains on any lone read
      if (enq & ~deq & ((wptr_r ^ 1'b1) == rptr_r))
      begin
        full_r <= 1'b1;
      end
      else if (deq & ~enq)
      begin
        full_r <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/me_stream_pump_in.sv
/*
 * buffers the inbound command stream and hands it to the responder as word beats
 * reads expand 1:N, writes pass beat for beat, addresses wrap from the critical word
 */
`timescale 1ns/1ps

module me_stream_pump_in
  (input                                                 clk_i
   , input                                               reset_i

   // inbound stream, the header repeats on every beat
   , input  me_stream_pkg::me_msg_type_e                 msg_type_i
   , input  [me_stream_pkg::paddr_width-1:0]             msg_addr_i
   , input  [me_stream_pkg::size_width-1:0]              msg_size_i
   , input  [me_stream_pkg::stream_data_width-1:0]       msg_data_i
   , input                                               msg_v_i
   , input                                               msg_last_i
   , output logic                                        msg_ready_and_o

   // word beats toward the responder
   , output me_stream_pkg::me_msg_type_e                 fsm_type_o
   , output logic [me_stream_pkg::paddr_width-1:0]       fsm_base_addr_o
   , output logic [me_stream_pkg::size_width-1:0]        fsm_size_o
   , output logic [me_stream_pkg::paddr_width-1:0]       fsm_addr_o
   , output logic [me_stream_pkg::stream_data_width-1:0] fsm_data_o
   , output logic                                        fsm_v_o
   , output logic                                        fsm_new_o
   , output logic                                        fsm_done_o
   , input                                               fsm_yumi_i
   );

  import me_stream_pkg::*;

  logic [1:0]                     msg_type_lo;
  logic [paddr_width-1:0]         msg_addr_lo;
  logic [size_width-1:0]          msg_size_lo;
  logic [stream_data_width-1:0]   msg_data_lo;
  logic                           msg_last_lo, msg_v_lo, msg_yumi_li;

  me_two_fifo
    #(.width_p(1 + $bits(me_msg_type_e) + paddr_width + size_width + stream_data_width))
    u_in_fifo
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .data_i({msg_last_i, msg_type_i, msg_addr_i, msg_size_i, msg_data_i})
     , .v_i(msg_v_i)
     , .ready_o(msg_ready_and_o)
     , .data_o({msg_last_lo, msg_type_lo, msg_addr_lo, msg_size_lo, msg_data_lo})
     , .v_o(msg_v_lo)
     , .yumi_i(msg_yumi_li)
     );

  logic [data_len_width-1:0]      num_stream;
  logic [data_len_width-1:0]      first_cnt, last_cnt, stream_cnt, wrap_cnt;
  logic [data_len_width-1:0]      current_cnt_r;
  logic [block_offset_width-1:0]  critical_addr_r, critical_addr;
  logic                           streaming_r, cnt_up, is_last_cnt;
  logic                           is_fsm_stream, is_msg_stream;

  // number of word beats minus one, zero for a single-word message
  assign num_stream = stream_len(msg_size_lo);

  // the critical offset is captured on the first beat and held while streaming
  // outside a stream the live header offset goes straight through
  always_ff @(posedge clk_i)
  begin
    if (~streaming_r)
    begin
      critical_addr_r <= msg_addr_lo[block_offset_width-1:0];
    end
  end

  assign critical_addr = streaming_r ? critical_addr_r : msg_addr_lo[block_offset_width-1:0];

  always_comb
  begin
    first_cnt = critical_addr[stream_offset_width+:data_len_width];
    // the last count wraps in the counter width, the mask below trims it to the sub-block
    last_cnt  = first_cnt + num_stream;

    is_fsm_stream = fsm_stream_mask[msg_type_lo] & (num_stream != '0);
    is_msg_stream = msg_stream_mask[msg_type_lo] & (num_stream != '0);

    stream_cnt  = streaming_r ? current_cnt_r : first_cnt;
    is_last_cnt = (stream_cnt == last_cnt) | (~is_fsm_stream & ~is_msg_stream);

    // count bits inside the sub-block follow the counter, the rest keep the critical word
    wrap_cnt = (stream_cnt & num_stream) | (first_cnt & ~num_stream);
  end

  // the beat counter steps on each yumi that is not the last, and clears on done
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      current_cnt_r <= '0;
      streaming_r   <= 1'b0;
    end
    else if (fsm_done_o)
    begin
      current_cnt_r <= '0;
      streaming_r   <= 1'b0;
    end
    else if (cnt_up)
    begin
      current_cnt_r <= (fsm_new_o ? first_cnt : current_cnt_r) + 1'b1;
      streaming_r   <= 1'b1;
    end
  end

  assign fsm_type_o      = me_msg_type_e'(msg_type_lo);
  assign fsm_size_o      = msg_size_lo;
  assign fsm_data_o      = msg_data_lo;
  assign fsm_base_addr_o = {msg_addr_lo[paddr_width-1:block_offset_width], critical_addr};
  assign fsm_addr_o      = {msg_addr_lo[paddr_width-1:block_offset_width]
                            , wrap_cnt
                            , msg_addr_lo[stream_offset_width-1:0]};

  // valid comes from the buffer alone and never from the yumi
  assign fsm_v_o = msg_v_lo;

  always_comb
  begin
    cnt_up  = fsm_yumi_i & ~is_last_cnt;
    if (is_fsm_stream & ~is_msg_stream)
    begin
      // one buffered read beat is shown n times and released on the final count
      msg_yumi_li = fsm_yumi_i & is_last_cnt & msg_last_lo;
    end
    else
    begin
      // every buffered beat is its own fsm beat
      msg_yumi_li = fsm_yumi_i;
    end
    fsm_new_o  = fsm_yumi_i & ~streaming_r;
    fsm_done_o = fsm_yumi_i & is_last_cnt;
  end

endmodule

// File: verilog/me_mem_responder.sv
/*
 * word memory behind the inbound pump, answers reads with data beats
 * and writes with a single zero-data acknowledge on the last beat
 */
`timescale 1ns/1ps

module me_mem_responder
  (input                                                 clk_i

   // word beats from the inbound pump
   , input  me_stream_pkg::me_msg_type_e                 fsm_type_i
   , input  [me_stream_pkg::paddr_width-1:0]             fsm_base_addr_i
   , input  [me_stream_pkg::size_width-1:0]              fsm_size_i
   , input  [me_stream_pkg::paddr_width-1:0]             fsm_addr_i
   , input  [me_stream_pkg::stream_data_width-1:0]       fsm_data_i
   , input                                               fsm_v_i
   , input                                               fsm_done_i
   , output logic                                        fsm_yumi_o

   // response beats toward the outbound pump
   , output me_stream_pkg::me_msg_type_e                 resp_type_o
   , output logic [me_stream_pkg::paddr_width-1:0]       resp_addr_o
   , output logic [me_stream_pkg::size_width-1:0]        resp_size_o
   , output logic [me_stream_pkg::stream_data_width-1:0] resp_data_o
   , output logic                                        resp_v_o
   , input                                               resp_ready_and_i
   );

  import me_stream_pkg::*;

  logic [stream_data_width-1:0] mem_r [mem_words];
  logic [mem_addr_width-1:0]    word_idx;
  logic [stream_data_width-1:0] rd_data;
  logic [data_len_width-1:0]    beat_len, crit_word, last_word;
  logic                         is_write, is_last_beat, needs_resp;

  // upper address bits alias onto the 64 words
  assign word_idx = fsm_addr_i[stream_offset_width+:mem_addr_width];
  assign rd_data  = mem_r[word_idx];

  always_comb
  begin
    unique case (fsm_type_i)
      e_wr_msg, e_uc_wr_msg: is_write = 1'b1;
      default:               is_write = 1'b0;
    endcase
  end

  // the last beat is the word just before the critical word in wrap order
  // it is found from the addresses because the done strobe already follows the yumi
  assign beat_len     = stream_len(fsm_size_i);
  assign crit_word    = fsm_base_addr_i[stream_offset_width+:data_len_width];
  assign last_word    = (crit_word & ~beat_len) | ((crit_word + beat_len) & beat_len);
  assign is_last_beat = (fsm_addr_i[stream_offset_width+:data_len_width] == last_word);

  // every read beat answers, a write answers once on its last beat
  assign needs_resp = ~is_write | is_last_beat;
  // the write acknowledge goes out together with the done beat
  assign resp_v_o   = fsm_v_i & (~is_write | fsm_done_i);

  // beats without a response are taken at once, others wait for the outbound buffer
  assign fsm_yumi_o = fsm_v_i & (~needs_resp | resp_ready_and_i);

  always_ff @(posedge clk_i)
  begin
    if (fsm_yumi_o & is_write)
    begin
      mem_r[word_idx] <= fsm_data_i;
    end
  end

  // the header goes back as the critical-word address with the original size
  assign resp_type_o = fsm_type_i;
  assign resp_addr_o = fsm_base_addr_i;
  assign resp_size_o = fsm_size_i;
  assign resp_data_o = is_write ? '0 : rd_data;

endmodule

// File: verilog/me_stream_pump_out.sv
/*
 * counts response beats per message, flags the final one as last
 * and buffers header, data and last toward the outbound stream
 */
`timescale 1ns/1ps

module me_stream_pump_out
  (input                                                 clk_i
   , input                                               reset_i

   // response beats from the responder
   , input  me_stream_pkg::me_msg_type_e                 fsm_type_i
   , input  [me_stream_pkg::paddr_width-1:0]             fsm_addr_i
   , input  [me_stream_pkg::size_width-1:0]              fsm_size_i
   , input  [me_stream_pkg::stream_data_width-1:0]       fsm_data_i
   , input                                               fsm_v_i
   , output logic                                        fsm_ready_and_o

   // outbound stream
   , output me_stream_pkg::me_msg_type_e                 msg_type_o
   , output logic [me_stream_pkg::paddr_width-1:0]       msg_addr_o
   , output logic [me_stream_pkg::size_width-1:0]        msg_size_o
   , output logic [me_stream_pkg::stream_data_width-1:0] msg_data_o
   , output logic                                        msg_v_o
   , output logic                                        msg_last_o
   , input                                               msg_ready_and_i
   );

  import me_stream_pkg::*;

  logic [data_len_width-1:0] cnt_r, last_cnt;
  logic [1:0]                msg_type_lo;
  logic                      is_last, accept;

  // reads return one beat per word, a write returns a single acknowledge
  always_comb
  begin
    unique case (fsm_type_i)
      e_rd_msg, e_uc_rd_msg: last_cnt = stream_len(fsm_size_i);
      default:               last_cnt = '0;
    endcase
  end

  assign is_last = (cnt_r == last_cnt);
  assign accept  = fsm_v_i & fsm_ready_and_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cnt_r <= '0;
    end
    else if (accept)
    begin
      cnt_r <= is_last ? '0 : cnt_r + 1'b1;
    end
  end

  me_two_fifo
    #(.width_p(1 + $bits(me_msg_type_e) + paddr_width + size_width + stream_data_width))
    u_out_fifo
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .data_i({is_last, fsm_type_i, fsm_addr_i, fsm_size_i, fsm_data_i})
     , .v_i(fsm_v_i)
     , .ready_o(fsm_ready_and_o)
     , .data_o({msg_last_o, msg_type_lo, msg_addr_o, msg_size_o, msg_data_o})
     , .v_o(msg_v_o)
     , .yumi_i(msg_v_o & msg_ready_and_i)
     );

  assign msg_type_o = me_msg_type_e'(msg_type_lo);

endmodule

// File: verilog/me_mem_endpoint.sv
/*
 * memory endpoint on a stream interface
 * requests pass the inbound pump, the word memory and the outbound pump in that order
 */
`timescale 1ns/1ps

module me_mem_endpoint
  (input                                                 clk_i
   , input                                               reset_i

   , input  me_stream_pkg::me_msg_type_e                 req_type_i
   , input  [me_stream_pkg::paddr_width-1:0]             req_addr_i
   , input  [me_stream_pkg::size_width-1:0]              req_size_i
   , input  [me_stream_pkg::stream_data_width-1:0]       req_data_i
   , input                                               req_v_i
   , input                                               req_last_i
   , output logic                                        req_ready_and_o

   , output me_stream_pkg::me_msg_type_e                 resp_type_o
   , output logic [me_stream_pkg::paddr_width-1:0]       resp_addr_o
   , output logic [me_stream_pkg::size_width-1:0]        resp_size_o
   , output logic [me_stream_pkg::stream_data_width-1:0] resp_data_o
   , output logic                                        resp_v_o
   , output logic                                        resp_last_o
   , input                                               resp_ready_and_i
   );

  import me_stream_pkg::*;

  me_msg_type_e                 fsm_type, mid_type;
  logic [paddr_width-1:0]       fsm_base_addr, fsm_addr, mid_addr;
  logic [size_width-1:0]        fsm_size, mid_size;
  logic [stream_data_width-1:0] fsm_data, mid_data;
  logic                         fsm_v, fsm_done, fsm_yumi;
  logic                         mid_v, mid_ready_and;

  me_stream_pump_in u_pump_in
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .msg_type_i(req_type_i)
     , .msg_addr_i(req_addr_i)
     , .msg_size_i(req_size_i)
     , .msg_data_i(req_data_i)
     , .msg_v_i(req_v_i)
     , .msg_last_i(req_last_i)
     , .msg_ready_and_o(req_ready_and_o)
     , .fsm_type_o(fsm_type)
     , .fsm_base_addr_o(fsm_base_addr)
     , .fsm_size_o(fsm_size)
     , .fsm_addr_o(fsm_addr)
     , .fsm_data_o(fsm_data)
     , .fsm_v_o(fsm_v)
     // only the pump's own counter needs the first-beat strobe
     , .fsm_new_o()
     , .fsm_done_o(fsm_done)
     , .fsm_yumi_i(fsm_yumi)
     );

  me_mem_responder u_responder
    (.clk_i(clk_i)
     , .fsm_type_i(fsm_type)
     , .fsm_base_addr_i(fsm_base_addr)
     , .fsm_size_i(fsm_size)
     , .fsm_addr_i(fsm_addr)
     , .fsm_data_i(fsm_data)
     , .fsm_v_i(fsm_v)
     , .fsm_done_i(fsm_done)
     , .fsm_yumi_o(fsm_yumi)
     , .resp_type_o(mid_type)
     , .resp_addr_o(mid_addr)
     , .resp_size_o(mid_size)
     , .resp_data_o(mid_data)
     , .resp_v_o(mid_v)
     , .resp_ready_and_i(mid_ready_and)
     );

  me_stream_pump_out u_pump_out
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .fsm_type_i(mid_type)
     , .fsm_addr_i(mid_addr)
     , .fsm_size_i(mid_size)
     , .fsm_data_i(mid_data)
     , .fsm_v_i(mid_v)
     , .fsm_ready_and_o(mid_ready_and)
     , .msg_type_o(resp_type_o)
     , .msg_addr_o(resp_addr_o)
     , .msg_size_o(resp_size_o)
     , .msg_data_o(resp_data_o)
     , .msg_v_o(resp_v_o)
     , .msg_last_o(resp_last_o)
     , .msg_ready_and_i(resp_ready_and_i)
     );

endmodule

// File: verif/me_mem_endpoint_tb.sv
/*
 * testbench for the memory endpoint, sends random request streams
 * and checks every response beat against a word memory model kept here
 */
`timescale 1ns/1ps

module me_mem_endpoint_tb;

  import me_stream_pkg::*;

  localparam int clk_period = 20;
  // 16 + 30 + 24 + 16 + 42 requests over the six tests
  localparam int total_reqs = 128;

  logic         clk_i, reset_i;
  me_msg_type_e req_type_i, resp_type_o;
  logic [31:0]  req_addr_i, resp_addr_o;
  logic [2:0]   req_size_i, resp_size_o;
  logic [63:0]  req_data_i, resp_data_o;
  logic         req_v_i, req_last_i, req_ready_and_o;
  logic         resp_v_o, resp_last_o, resp_ready_and_i;

  // word memory model and the expected response beats in order
  logic [63:0]  model [64];
  logic [1:0]   q_type [$];
  logic [31:0]  q_addr [$];
  logic [2:0]   q_size [$];
  logic [63:0]  q_data [$];
  bit           q_last [$];
  bit           q_first [$];

  int cyc = 0;
  int errors = 0;
  int checks = 0;
  int test_num = 0;
  int test_err_start = 0;
  int last_accept_cyc, first_beat_cyc;
  bit bp_on = 1'b0;
  bit gaps_on = 1'b0;

  me_mem_endpoint u_dut
    (.clk_i(clk_i)
     , .reset_i(reset_i)
     , .req_type_i(req_type_i)
     , .req_addr_i(req_addr_i)
     , .req_size_i(req_size_i)
     , .req_data_i(req_data_i)
     , .req_v_i(req_v_i)
     , .req_last_i(req_last_i)
     , .req_ready_and_o(req_ready_and_o)
     , .resp_type_o(resp_type_o)
     , .resp_addr_o(resp_addr_o)
     , .resp_size_o(resp_size_o)
     , .resp_data_o(resp_data_o)
     , .resp_v_o(resp_v_o)
     , .resp_last_o(resp_last_o)
     , .resp_ready_and_i(resp_ready_and_i)
     );

  initial
  begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // cycle count, read only at falling edges where it is stable
  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // beat k starts at the critical word and wraps inside the aligned group of n words
  function automatic int wrap_idx(input int c, input int k, input int n);
    return ((c + k) % n) + (c - c % n);
  endfunction

  function automatic logic [31:0] rand_addr(input int upper_odds);
    logic [22:0] upper;
    upper = '0;
    // a few requests carry upper bits that the memory has to alias away
    if (upper_odds != 0 && $urandom_range(0, upper_odds - 1) == 0)
    begin
      upper = 23'($urandom);
    end
    return {upper, 6'($urandom_range(0, 63)), 3'b000};
  endfunction

  task automatic push_beat(input me_msg_type_e t, input logic [31:0] a, input logic [2:0] s,
                           input logic [63:0] d, input bit last, input bit first);
    q_type.push_back(t);
    q_addr.push_back(a);
    q_size.push_back(s);
    q_data.push_back(d);
    q_last.push_back(last);
    q_first.push_back(first);
  endtask

  // called at a falling edge, returns at the falling edge after the last beat transfers
  task automatic send_req(input me_msg_type_e t, input logic [31:0] addr, input logic [2:0] size);
    int n, c, blk, beats, k, j, gap;
    logic [63:0] d;
    bit is_wr;
    n = (size > 3) ? (1 << (size - 3)) : 1;
    c = addr[5:3];
    blk = addr[8:6];
    is_wr = (t == e_wr_msg) || (t == e_uc_wr_msg);
    beats = is_wr ? n : 1;
    for (k = 0; k < beats; k++)
    begin
      gap = gaps_on ? $urandom_range(0, 2) : 0;
      if (gap != 0)
      begin
        req_v_i = 1'b0;
        repeat (gap) @(negedge clk_i);
      end
      d = {$urandom, $urandom};
      req_type_i = t;
      req_addr_i = addr;
      req_size_i = size;
      req_data_i = d;
      req_last_i = (k == beats - 1);
      req_v_i = 1'b1;
      // ready only depends on buffer state, so it holds until the next rising edge
      while (req_ready_and_o !== 1'b1) @(negedge clk_i);
      if (is_wr)
      begin
        model[blk * 8 + wrap_idx(c, k, n)] = d;
      end
      if (k == beats - 1)
      begin
        last_accept_cyc = cyc;
        if (is_wr)
        begin
          push_beat(t, addr, size, 64'h0, 1'b1, 1'b1);
        end
        else
        begin
          for (j = 0; j < n; j++)
          begin
            push_beat(t, addr, size, model[blk * 8 + wrap_idx(c, j, n)], j == n - 1, j == 0);
          end
        end
      end
      @(negedge clk_i);
    end
    req_v_i = 1'b0;
    req_last_i = 1'b0;
  endtask

  task automatic random_op(input int upper_odds);
    send_req(me_msg_type_e'($urandom_range(0, 3)), rand_addr(upper_odds),
             3'($urandom_range(3, 6)));
  endtask

  task automatic wait_drain();
    while (q_data.size() != 0) @(negedge clk_i);
    repeat (3) @(negedge clk_i);
  endtask

  task automatic start_test();
    test_num++;
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    wait_drain();
    $display("test %0d %s finished with %0d errors", test_num, name, errors - test_err_start);
  endtask

  // response side, ready is chosen at each falling edge and a beat moves at the next rising one
  initial
  begin
    forever
    begin
      @(negedge clk_i);
      resp_ready_and_i = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (!reset_i && resp_v_o === 1'b1 && resp_ready_and_i)
      begin
        checks++;
        assert (q_data.size() != 0)
        else
        begin
          $display("response beat arrived while no response was expected");
          errors++;
        end
        if (q_data.size() != 0)
        begin
          if (q_first[0])
          begin
            first_beat_cyc = cyc;
          end
          check_val("resp_type_o", q_type.pop_front(), resp_type_o);
          check_val("resp_addr_o", q_addr.pop_front(), resp_addr_o);
          check_val("resp_size_o", q_size.pop_front(), resp_size_o);
          check_val("resp_data_o", q_data.pop_front(), resp_data_o);
          check_val("resp_last_o", q_last.pop_front(), resp_last_o);
          void'(q_first.pop_front());
        end
      end
    end
  end

  // watchdog sized from the number of requests
  initial
  begin
    #(total_reqs * 200 * clk_period);
    $display("timeout, the responses did not all arrive in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    int i, b;
    logic [31:0] a;
    logic [2:0] s;
    void'($urandom(32'h6804));
    reset_i = 1'b1;
    req_type_i = e_rd_msg;
    req_addr_i = '0;
    req_size_i = 3'd3;
    req_data_i = '0;
    req_v_i = 1'b0;
    req_last_i = 1'b0;
    resp_ready_and_i = 1'b0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    // idle after reset, nothing may come out
    start_test();
    check_val("req_ready_and_o", 1'b1, req_ready_and_o);
    check_val("resp_v_o", 1'b0, resp_v_o);
    repeat (10)
    begin
      @(negedge clk_i);
      check_val("resp_v_o", 1'b0, resp_v_o);
    end
    end_test("reset state");

    // filling every block first leaves no unwritten word for later reads
    start_test();
    bp_on = 1'b1;
    for (b = 0; b < 8; b++)
    begin
      send_req($urandom_range(0, 1) ? e_wr_msg : e_uc_wr_msg,
               {23'h0, 3'(b), 3'($urandom_range(0, 7)), 3'b000}, 3'd6);
    end
    for (i = 0; i < 8; i++)
    begin
      send_req($urandom_range(0, 1) ? e_rd_msg : e_uc_rd_msg, rand_addr(0), 3'd6);
    end
    end_test("full block write and read");

    // partial write, same size read, then the whole block to see the other words
    start_test();
    for (i = 0; i < 10; i++)
    begin
      a = rand_addr(0);
      s = 3'($urandom_range(4, 5));
      send_req(e_wr_msg, a, s);
      send_req(e_rd_msg, {a[31:6], 3'($urandom_range(0, 7)), 3'b000}, s);
      send_req(e_rd_msg, {a[31:6], 3'($urandom_range(0, 7)), 3'b000}, 3'd6);
    end
    end_test("16 and 32 byte wrap");

    start_test();
    for (i = 0; i < 24; i++)
    begin
      send_req(me_msg_type_e'($urandom_range(0, 3)), rand_addr(3), 3'd3);
    end
    end_test("single word and aliasing");

    // every type with every size, headers are checked on each beat
    start_test();
    for (i = 0; i < 16; i++)
    begin
      send_req(me_msg_type_e'(i % 4), rand_addr(0), 3'(3 + i / 4));
    end
    end_test("response headers");

    start_test();
    gaps_on = 1'b1;
    for (i = 0; i < 40; i++)
    begin
      random_op(8);
    end
    wait_drain();
    // with the pipeline empty and ready held high the latency is fixed
    gaps_on = 1'b0;
    bp_on = 1'b0;
    send_req(e_rd_msg, rand_addr(0), 3'd6);
    wait_drain();
    check_val("read latency", 2, first_beat_cyc - last_accept_cyc);
    send_req(e_wr_msg, rand_addr(0), 3'd6);
    wait_drain();
    check_val("write latency", 2, first_beat_cyc - last_accept_cyc);
    end_test("back-pressure, order and latency");

    $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/me_stream_pkg.sv
verilog/me_two_fifo.sv
verilog/me_stream_pump_in.sv
verilog/me_mem_responder.sv
verilog/me_stream_pump_out.sv
verilog/me_mem_endpoint.sv
verif/me_mem_endpoint_tb.sv
